// File: mem_access_router.f
verilog/access_pkg.sv
verilog/periph_pkg.sv
verilog/access_decode.sv
verilog/periph_sequencer.sv
verilog/access_writeback.sv
verilog/mem_access_router.sv
test/router_checker.sv
test/tb_mem_access_router.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f mem_access_router.f \
    --top-module tb_mem_access_router \
    -o sim_router \
    && ./obj_dir/sim_router | tee /dev/stderr | grep -q "TEST OK" \
    && exit 0 \
    || exit 1

// File: test/router_cases.txt
// kind addr wdata wstrb periph_rdata periph_delay expected_proc_rdata
// kind 1 load, 2 store; proc_rdata only compared on loads
1 00001000 00000000 0 00000000 00 ffffefff
2 00002004 a5a5a5a5 f 00000000 00 00000000
2 00010150 00000041 1 00000000 00 00000000
2 00010154 00000042 1 00000000 00 00000000
2 10000008 deadbeef f 00000000 02 00000000
1 1000000c 00000000 0 12345678 03 12345678
1 00003000 00000000 0 00000000 00 ffffcfff
1 20000000 00000000 0 cafef00d 00 cafef00d
2 10000010 0badf00d 3 00000000 01 00000000
1 10000014 00000000 0 55aa55aa 05 55aa55aa
2 00010150 0000000a 1 00000000 00 00000000
1 000000fc 00000000 0 00000000 00 ffffff03

// File: test/tb_mem_access_router.sv
module tb_mem_access_router
    import access_pkg::*;
    import periph_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CASES = 12;
    localparam int CASE_WORDS = 7;
    localparam int CLK_HALF = 20;
    localparam int WAIT_LIMIT = 200;
    localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h10000000;
    localparam logic [ADDR_W-1:0] CONSOLE_ADDR = 32'h00010150;

    logic              CLK = 1'b0;
    logic              rst_n = 1'b0;
    access_req_t       proc_req = '0;
    logic              proc_ready;
    logic [DATA_W-1:0] proc_rdata;
    access_req_t       cache_req;
    logic              cache_ready = 1'b1;
    logic [DATA_W-1:0] cache_rdata;
    logic              console_wr_en;
    logic [DATA_W-1:0] console_wr_data;
    periph_req_t       periph_req;
    logic              rd_valid;
    logic              rd_ready = 1'b0;
    logic              wr_valid;
    logic              wr_ready = 1'b0;
    logic [DATA_W-1:0] periph_rdata = '0;
    logic              rdata_valid = 1'b0;
    logic              rdata_ready;

    logic [31:0]       cases [0:NUM_CASES*CASE_WORDS-1];
    logic              active = 1'b0;
    int                case_no = 0;
    access_req_t       exp_req = '0;
    logic              exp_periph = 1'b0;
    logic              exp_console = 1'b0;
    logic [DATA_W-1:0] exp_rdata = '0;
    logic [DATA_W-1:0] cur_prdata = '0;
    int                cur_delay = 0;
    int                wait_cnt = 0;
    int                seed = 32'hedb44872;
    logic              timed_out = 1'b0;
    int                pass_cnt;
    int                fail_cnt;

    always #(CLK_HALF) CLK = ~CLK;

    // Cache model answers at once with the inverted address
    assign cache_rdata = ~cache_req.addr;

    mem_access_router #(
        .PERIPH_BASE  (PERIPH_BASE),
        .CONSOLE_ADDR (CONSOLE_ADDR)
    ) mem_access_router_i (
        .CLK             (CLK),
        .rst_n           (rst_n),
        .proc_req        (proc_req),
        .proc_ready      (proc_ready),
        .proc_rdata      (proc_rdata),
        .cache_req       (cache_req),
        .cache_ready     (cache_ready),
        .cache_rdata     (cache_rdata),
        .console_wr_en   (console_wr_en),
        .console_wr_data (console_wr_data),
        .periph_req      (periph_req),
        .rd_valid        (rd_valid),
        .rd_ready        (rd_ready),
        .wr_valid        (wr_valid),
        .wr_ready        (wr_ready),
        .periph_rdata    (periph_rdata),
        .rdata_valid     (rdata_valid),
        .rdata_ready     (rdata_ready)
    );

    router_checker router_checker_i (
        .CLK             (CLK),
        .rst_n           (rst_n),
        .proc_ready      (proc_ready),
        .proc_rdata      (proc_rdata),
        .cache_req       (cache_req),
        .console_wr_en   (console_wr_en),
        .console_wr_data (console_wr_data),
        .periph_req      (periph_req),
        .rd_valid        (rd_valid),
        .wr_valid        (wr_valid),
        .rdata_ready     (rdata_ready),
        .seq_state       (mem_access_router_i.periph_sequencer_i.state),
        .active          (active),
        .case_no         (case_no),
        .exp_req         (exp_req),
        .exp_periph      (exp_periph),
        .exp_console     (exp_console),
        .exp_rdata       (exp_rdata),
        .pass_cnt        (pass_cnt),
        .fail_cnt        (fail_cnt)
    );

    //////////////////////////////
    // Peripheral model
    //////////////////////////////

    always @(negedge CLK)
    begin
        rd_ready    = 1'b0;
        wr_ready    = 1'b0;
        rdata_valid = 1'b0;
        if (rst_n && (rd_valid || wr_valid || rdata_ready))
        begin
            if (wait_cnt >= cur_delay)
            begin
                wait_cnt = 0;
                if (rdata_ready)
                begin
                    rdata_valid  = 1'b1;
                    periph_rdata = cur_prdata;
                end
                else if (rd_valid)
                begin
                    rd_ready = 1'b1;
                end
                else
                begin
                    wr_ready = 1'b1;
                end
            end
            else
            begin
                wait_cnt++;
            end
        end
    end

    // Polls proc_ready mid-cycle until it reaches the given level
    task automatic wait_proc_ready(input logic level);
        int n;
        n = 0;
        @(negedge CLK);
        while ((proc_ready !== level) && !timed_out)
        begin
            if (n >= WAIT_LIMIT)
            begin
                timed_out = 1'b1;
            end
            else
            begin
                @(negedge CLK);
                n++;
            end
        end
    endtask

    task automatic run_case(input int idx);
        int b;
        b = idx * CASE_WORDS;
        @(negedge CLK);
        proc_req.kind  = access_kind_e'(cases[b][1:0]);
        proc_req.addr  = cases[b+1];
        proc_req.wdata = cases[b+2];
        proc_req.wstrb = cases[b+3][STRB_W-1:0];
        cur_prdata     = cases[b+4];
        cur_delay      = int'(cases[b+5]) + int'($unsigned($random(seed)) % 32'd3);
        exp_rdata      = cases[b+6];
        exp_req        = proc_req;
        exp_periph     = (proc_req.addr >= PERIPH_BASE);
        exp_console    = !exp_periph && (proc_req.addr == CONSOLE_ADDR);
        case_no        = idx + 1;
        active         = 1'b1;
        if (exp_periph)
        begin
            // Accept edge, then stall, then release
            @(posedge CLK);
            wait_proc_ready(1'b0);
            if (!timed_out)
            begin
                wait_proc_ready(1'b1);
            end
        end
        @(posedge CLK);
    endtask

    initial
    begin
        int i;
        $readmemh("test/router_cases.txt", cases);
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        for (i = 0; i < NUM_CASES; i++)
        begin
            if (!timed_out)
            begin
                run_case(i);
            end
        end
        @(negedge CLK);
        active = 1'b0;
        repeat (3) @(negedge CLK);
        $display("passed %0d failed %0d", pass_cnt, fail_cnt);
        if (timed_out)
        begin
            $display("Timed out waiting for proc_ready in case %0d", case_no);
            $display("TEST FAILED");
        end
        else if ((fail_cnt == 0) && (pass_cnt == NUM_CASES))
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: test/router_checker.sv
module router_checker
    import access_pkg::*;
    import periph_pkg::*;
(
    input  logic              CLK,
    input  logic              rst_n,

    // DUT ports
    input  logic              proc_ready,
    input  logic [DATA_W-1:0] proc_rdata,
    input  access_req_t       cache_req,
    input  logic              console_wr_en,
    input  logic [DATA_W-1:0] console_wr_data,
    input  periph_req_t       periph_req,
    input  logic              rd_valid,
    input  logic              wr_valid,
    input  logic              rdata_ready,
    input  periph_state_e     seq_state,

    // Current access from the testbench
    input  logic              active,
    input  int                case_no,
    input  access_req_t       exp_req,
    input  logic              exp_periph,
    input  logic              exp_console,
    input  logic [DATA_W-1:0] exp_rdata,

    output int                pass_cnt,
    output int                fail_cnt
);

    timeunit 1ns;
    timeprecision 1ps;

    int                passes = 0;
    int                fails = 0;
    logic              rst_seen = 1'b0;
    logic              stalled = 1'b0;
    logic              err_cur = 1'b0;
    logic              err_done = 1'b0;
    logic              wrap = 1'b0;
    logic              done_console = 1'b0;
    int                done_case = 0;
    logic [DATA_W-1:0] done_wdata = '0;

    assign pass_cnt = passes;
    assign fail_cnt = fails;

    task automatic check_value(input int cno, input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout logic flag);
        if (got !== exp)
        begin
            $display("Error case %0d: %s got %h expected %h (state %s)",
                     cno, name, got, exp, seq_state.name());
            flag = 1'b1;
        end
    endtask

    always @(posedge CLK)
    begin
        if (!rst_n)
        begin
            if (rst_seen && (rd_valid || wr_valid || rdata_ready || console_wr_en))
            begin
                $display("Error reset: rd_valid %h wr_valid %h rdata_ready %h console_wr_en %h",
                         rd_valid, wr_valid, rdata_ready, console_wr_en);
                fails++;
            end
            rst_seen = 1'b1;
        end
        else
        begin
            //////////////////////////////
            // Close the previous access
            //////////////////////////////
            if (wrap)
            begin
                check_value(done_case, "console_wr_en", 32'(console_wr_en),
                            32'(done_console), err_done);
                if (done_console && console_wr_en)
                begin
                    check_value(done_case, "console_wr_data", console_wr_data, done_wdata,
                                err_done);
                end
                if (err_done)
                begin
                    $display("case %0d failed", done_case);
                    fails++;
                end
                else
                begin
                    $display("case %0d passed", done_case);
                    passes++;
                end
                wrap = 1'b0;
            end
            else if (console_wr_en)
            begin
                $display("Error case %0d: console write strobe without a console store",
                         case_no);
                if (active)
                begin
                    err_cur = 1'b1;
                end
                else
                begin
                    fails++;
                end
            end

            if (active)
            begin
                // Cache only sees its own range
                if (!exp_periph && !exp_console)
                begin
                    check_value(case_no, "cache_req.kind", 32'(cache_req.kind),
                                32'(exp_req.kind), err_cur);
                    check_value(case_no, "cache_req.addr", cache_req.addr, exp_req.addr,
                                err_cur);
                    check_value(case_no, "cache_req.wdata", cache_req.wdata, exp_req.wdata,
                                err_cur);
                    check_value(case_no, "cache_req.wstrb", 32'(cache_req.wstrb),
                                32'(exp_req.wstrb), err_cur);
                end
                else
                begin
                    check_value(case_no, "cache_req.kind", 32'(cache_req.kind),
                                32'(ACC_NONE), err_cur);
                end

                if (wr_valid || rd_valid)
                begin
                    check_value(case_no, "wr_valid", 32'(wr_valid),
                                32'(exp_req.kind == ACC_STORE), err_cur);
                    check_value(case_no, "rd_valid", 32'(rd_valid),
                                32'(exp_req.kind == ACC_LOAD), err_cur);
                    check_value(case_no, "periph_req.addr", periph_req.addr, exp_req.addr,
                                err_cur);
                    check_value(case_no, "periph_req.wdata", periph_req.wdata,
                                exp_req.wdata, err_cur);
                    check_value(case_no, "periph_req.wstrb", 32'(periph_req.wstrb),
                                32'(exp_req.wstrb), err_cur);
                end

                // Read data is awaited only once the read address is taken
                check_value(case_no, "rdata_ready", 32'(rdata_ready),
                            32'(!proc_ready && exp_periph && (exp_req.kind == ACC_LOAD) &&
                                !rd_valid), err_cur);

                if (!proc_ready)
                begin
                    if (!exp_periph)
                    begin
                        $display("Error case %0d: proc_ready dropped on a non-peripheral access",
                                 case_no);
                        err_cur = 1'b1;
                    end
                    stalled = 1'b1;
                end
                else if (!exp_periph || stalled)
                begin
                    // Access completes at this edge
                    if (exp_req.kind == ACC_LOAD)
                    begin
                        check_value(case_no, "proc_rdata", proc_rdata, exp_rdata, err_cur);
                    end
                    err_done     = err_cur;
                    err_cur      = 1'b0;
                    stalled      = 1'b0;
                    done_case    = case_no;
                    done_console = exp_console && (exp_req.kind == ACC_STORE);
                    done_wdata   = exp_req.wdata;
                    wrap         = 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/mem_access_router.sv
module mem_access_router
    import access_pkg::*;
    import periph_pkg::*;
#(
    parameter logic [ADDR_W-1:0] PERIPH_BASE  = 32'h10000000,
    parameter logic [ADDR_W-1:0] CONSOLE_ADDR = 32'h00010150
)
(
    input  logic              CLK,
    input  logic              rst_n,

    // Processor data port
    input  access_req_t       proc_req,
    output logic              proc_ready,
    output logic [DATA_W-1:0] proc_rdata,

    // Data cache
    output access_req_t       cache_req,
    input  logic              cache_ready,
    input  logic [DATA_W-1:0] cache_rdata,

    // Console
    output logic              console_wr_en,
    output logic [DATA_W-1:0] console_wr_data,

    // Peripheral bus
    output periph_req_t       periph_req,
    output logic              rd_valid,
    input  logic              rd_ready,
    output logic              wr_valid,
    input  logic              wr_ready,
    input  logic [DATA_W-1:0] periph_rdata,
    input  logic              rdata_valid,
    output logic              rdata_ready
);

    region_e           region;
    logic              stall;
    logic [DATA_W-1:0] periph_data;
    logic              periph_data_sel;

    assign proc_ready = cache_ready && !stall;

    access_decode #(
        .PERIPH_BASE  (PERIPH_BASE),
        .CONSOLE_ADDR (CONSOLE_ADDR)
    ) access_decode_i (
        .proc_req  (proc_req),
        .region    (region),
        .cache_req (cache_req)
    );

    periph_sequencer periph_sequencer_i (
        .CLK             (CLK),
        .rst_n           (rst_n),
        .proc_req        (proc_req),
        .region          (region),
        .cache_ready     (cache_ready),
        .stall           (stall),
        .periph_req      (periph_req),
        .rd_valid        (rd_valid),
        .rd_ready        (rd_ready),
        .wr_valid        (wr_valid),
        .wr_ready        (wr_ready),
        .periph_rdata    (periph_rdata),
        .rdata_valid     (rdata_valid),
        .rdata_ready     (rdata_ready),
        .periph_data     (periph_data),
        .periph_data_sel (periph_data_sel)
    );

    access_writeback access_writeback_i (
        .CLK             (CLK),
        .rst_n           (rst_n),
        .proc_req        (proc_req),
        .region          (region),
        .proc_ready      (proc_ready),
        .cache_rdata     (cache_rdata),
        .periph_data     (periph_data),
        .periph_data_sel (periph_data_sel),
        .console_wr_en   (console_wr_en),
        .console_wr_data (console_wr_data),
        .proc_rdata      (proc_rdata)
    );

endmodule

// File: verilog/access_writeback.sv
module access_writeback
    import access_pkg::*;
(
    input  logic              CLK,
    input  logic              rst_n,

    input  access_req_t       proc_req,
    input  region_e           region,
    input  logic              proc_ready,

    input  logic [DATA_W-1:0] cache_rdata,
    input  logic [DATA_W-1:0] periph_data,
    input  logic              periph_data_sel,

    output logic              console_wr_en,
    output logic [DATA_W-1:0] console_wr_data,
    output logic [DATA_W-1:0] proc_rdata
);

    logic console_store;

    assign console_store = proc_ready && (region == REG_CONSOLE) &&
                           (proc_req.kind == ACC_STORE);

    //////////////////////////////
    // Console capture
    //////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            console_wr_en <= 1'b0;
        end
        else
        begin
            console_wr_en <= console_store;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (console_store)
        begin
            console_wr_data <= proc_req.wdata;
        end
    end

    // Peripheral data only in the release cycle
    assign proc_rdata = periph_data_sel ? periph_data : cache_rdata;

endmodule

// File: verilog/periph_sequencer.sv
module periph_sequencer
    import access_pkg::*;
    import periph_pkg::*;
(
    input  logic              CLK,
    input  logic              rst_n,

    input  access_req_t       proc_req,
    input  region_e           region,
    input  logic              cache_ready,
    output logic              stall,

    output periph_req_t       periph_req,
    output logic              rd_valid,
    input  logic              rd_ready,
    output logic              wr_valid,
    input  logic              wr_ready,
    input  logic [DATA_W-1:0] periph_rdata,
    input  logic              rdata_valid,
    output logic              rdata_ready,

    output logic [DATA_W-1:0] periph_data,
    output logic              periph_data_sel
);

    periph_state_e     state;
    periph_req_t       req_q;
    logic              is_write;
    logic [DATA_W-1:0] rdata_q;
    logic              accept;

    assign accept = (state == PS_IDLE) && cache_ready &&
                    (region == REG_PERIPH) && (proc_req.kind != ACC_NONE);

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            state <= PS_IDLE;
        end
        else
        begin
            case (state)
                PS_IDLE:
                begin
                    if (accept)
                    begin
                        state <= PS_ADDR;
                    end
                end
                PS_ADDR:
                begin
                    // Stores finish on the write handshake
                    if (is_write && wr_ready)
                    begin
                        state <= PS_RELEASE;
                    end
                    else if (!is_write && rd_ready)
                    begin
                        state <= PS_DATA;
                    end
                end
                PS_DATA:
                begin
                    if (rdata_valid)
                    begin
                        state <= PS_RELEASE;
                    end
                end
                PS_RELEASE:
                begin
                    // Wait for the processor to take the result
                    if (cache_ready)
                    begin
                        state <= PS_IDLE;
                    end
                end
                default:
                begin
                    state <= PS_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Request and read data
    //////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_q.addr  <= proc_req.addr;
            req_q.wdata <= proc_req.wdata;
            req_q.wstrb <= proc_req.wstrb;
            is_write    <= (proc_req.kind == ACC_STORE);
        end
        if ((state == PS_DATA) && rdata_valid)
        begin
            rdata_q <= periph_rdata;
        end
    end

    assign periph_req  = req_q;
    assign wr_valid    = (state == PS_ADDR) && is_write;
    assign rd_valid    = (state == PS_ADDR) && !is_write;
    assign rdata_ready = (state == PS_DATA);

    // Processor held from the cycle after acceptance up to release
    assign stall = (state == PS_ADDR) || (state == PS_DATA);

    assign periph_data     = rdata_q;
    assign periph_data_sel = (state == PS_RELEASE);

endmodule

// File: verilog/access_decode.sv
module access_decode
    import access_pkg::*;
#(
    parameter logic [ADDR_W-1:0] PERIPH_BASE  = 32'h10000000,
    parameter logic [ADDR_W-1:0] CONSOLE_ADDR = 32'h00010150
)
(
    input  access_req_t proc_req,
    output region_e     region,
    output access_req_t cache_req
);

    logic is_console;
    logic is_periph;

    assign is_console = (proc_req.addr == CONSOLE_ADDR);
    assign is_periph  = (proc_req.addr >= PERIPH_BASE);

    // Peripheral range wins if the console sits above the base
    always_comb
    begin
        if (is_periph)
        begin
            region = REG_PERIPH;
        end
        else if (is_console)
        begin
            region = REG_CONSOLE;
        end
        else
        begin
            region = REG_CACHE;
        end
    end

    // Cache only sees accesses inside its own range
    always_comb
    begin
        cache_req = proc_req;
        if (region != REG_CACHE)
        begin
            cache_req.kind = ACC_NONE;
        end
    end

endmodule

// File: verilog/periph_pkg.sv
package periph_pkg;

    import access_pkg::*;

    //////////////////////////////
    // Peripheral bus request
    //////////////////////////////

    // Address, write data and strobes, held while a valid is up
    typedef struct packed
    {
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
        logic [STRB_W-1:0]   wstrb;
    } periph_req_t;

    //////////////////////////////
    // Sequencer states
    //////////////////////////////

    // Address phase covers both the read and the write channel;
    // data phase only follows a read
    typedef enum logic [1:0]
    {
        PS_IDLE    = 2'd0,
        PS_ADDR    = 2'd1,
        PS_DATA    = 2'd2,
        PS_RELEASE = 2'd3
    } periph_state_e;

endpackage

// File: verilog/access_pkg.sv
package access_pkg;

    //////////////////////////////
    // Processor data port widths
    //////////////////////////////

    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    parameter int STRB_W = 4;

    // Store uses the value 2, as the processor encodes it
    typedef enum logic [1:0]
    {
        ACC_NONE  = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } access_kind_e;

    // Shared by the processor port and the cache port
    typedef struct packed
    {
        access_kind_e        kind;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
        logic [STRB_W-1:0]   wstrb;
    } access_req_t;

    //////////////////////////////
    // Address regions
    //////////////////////////////

    typedef enum logic [1:0]
    {
        REG_CACHE   = 2'd0,
        REG_CONSOLE = 2'd1,
        REG_PERIPH  = 2'd2
    } region_e;

endpackage
